//--- rtl/agc_pkg.sv
`default_nettype none

package agc_pkg;

    localparam int ADR_W = 22;
    localparam int DAT_W = 32;
    localparam int THR_W = 18;

    typedef logic [ADR_W-1:0] adr_t;
    typedef logic [DAT_W-1:0] dat_t;
    typedef logic [THR_W-1:0] thr_t;
    typedef logic [31:0]      count_t; // Triggers seen in one count period

    localparam thr_t START_THRESH      = 18'd4500;
    localparam int   BOOT_DELAY_CYCLES = 31;

    ////////////////////////////////////////////////////////////////////////////
    // Host register map
    localparam adr_t ADR_CMD         = 22'h001000;
    localparam adr_t ADR_MANUAL_BASE = 22'h000800;
    localparam adr_t MANUAL_MASK     = 22'h003800;

    ////////////////////////////////////////////////////////////////////////////
    // Trigger core register map
    localparam adr_t CORE_ADR_CTRL      = 22'h000000;
    localparam adr_t CORE_ADR_BEAM_BASE = 22'h000400; // Count on read, threshold on write
    localparam adr_t CORE_ADR_CE_BASE   = 22'h000800; // Per-beam threshold enable
    localparam dat_t CORE_START         = 32'd1;
    localparam dat_t CORE_APPLY         = 32'd2;

    // Command register data
    typedef enum logic [DAT_W-1:0] {
        CMD_RESET = 0,
        CMD_RUN   = 1,
        CMD_PAUSE = 2
    } loop_cmd_e;

    typedef enum logic [2:0] {
        RUNNING,
        RESETTING,
        WRITE_RESET,
        STOPPED,
        WRITE_MANUAL,
        WRITE_MANUAL_DONE
    } loop_state_e;

    typedef enum logic [2:0] {IDLE, WRITE, WAIT, READ, ACK} host_state_e;

    typedef enum logic [3:0] {
        BOOT, POLL, WAIT_COUNT, READ_COUNTS, CALC,
        WRITE_THR, APPLY_CE, UPDATE, RESET_THR, MANUAL
    } seq_state_e;

    typedef enum logic [1:0] {SEND, WAIT_ACK, PROCESS} bus_phase_e;

endpackage

`default_nettype wire

//--- rtl/agc_host_decode.sv
`default_nettype none

module agc_host_decode #(
    parameter int  NBEAMS     = 2,
    parameter int  STEP_DELTA = 2,
    localparam int BEAM_W     = (NBEAMS > 1) ? $clog2(NBEAMS) : 1
) (
    input  wire                       wb_clk_i,
    input  wire                       agc_reset,
    input  wire                       wb_cyc_i,
    input  wire                       wb_stb_i,
    input  wire                       wb_we_i,
    input  wire agc_pkg::adr_t        wb_adr_i,
    input  wire agc_pkg::dat_t        wb_dat_i,
    output logic                      wb_ack_o,
    output agc_pkg::dat_t             wb_dat_o,
    input  wire agc_pkg::loop_state_e loop_state_i,
    output agc_pkg::loop_state_e      loop_req_o,
    input  wire agc_pkg::count_t      rd_count_i,
    input  wire agc_pkg::thr_t        rd_thr_i,
    output logic                      man_wr_o,
    output logic [BEAM_W-1:0]         man_beam_o,
    output agc_pkg::thr_t             man_thr_o,
    output logic [BEAM_W-1:0]         rd_beam_o
);

    import agc_pkg::*;

    host_state_e host_state;
    logic        is_cmd;
    logic        is_manual;
    logic        man_ok;

    assign is_cmd    = (wb_adr_i[13:0] == ADR_CMD[13:0]);
    assign is_manual = ((wb_adr_i & MANUAL_MASK) == (ADR_MANUAL_BASE & MANUAL_MASK));
    // Only one manual write in flight, and only while paused
    assign man_ok    = (loop_state_i == STOPPED) && (loop_req_o != WRITE_MANUAL_DONE);

    assign rd_beam_o = wb_adr_i[2 +: BEAM_W];
    assign wb_ack_o  = (host_state == ACK);

    ////////////////////////////////////////////////////////////////////////////
    // Host target FSM
    always_ff @(posedge wb_clk_i) begin
        if (agc_reset) begin
            host_state <= IDLE;
            loop_req_o <= RUNNING;
            man_wr_o   <= 1'b0;
        end else begin
            man_wr_o <= 1'b0;
            case (host_state)
                IDLE: begin
                    if (wb_cyc_i && wb_stb_i)
                        host_state <= wb_we_i ? WRITE : READ;
                end
                READ: begin
                    host_state <= ACK;
                    if (wb_adr_i[10])
                        wb_dat_o <= rd_count_i;                      // Last count
                    else if (wb_adr_i[11])
                        wb_dat_o <= dat_t'(rd_thr_i);                // Current threshold
                    else
                        wb_dat_o <= dat_t'(STEP_DELTA);
                end
                WRITE: begin
                    host_state <= WAIT;
                    if (is_cmd) begin
                        case (wb_dat_i)
                            CMD_RESET: loop_req_o <= RESETTING;
                            CMD_RUN:   loop_req_o <= RUNNING;
                            CMD_PAUSE: loop_req_o <= STOPPED;
                            default:   ;                              // Unknown command ignored
                        endcase
                    end else if (is_manual) begin
                        if (man_ok) begin
                            man_wr_o   <= 1'b1;
                            man_beam_o <= wb_adr_i[2 +: BEAM_W];
                            man_thr_o  <= wb_dat_i[THR_W-1:0];
                            loop_req_o <= WRITE_MANUAL_DONE;
                            wb_dat_o   <= dat_t'(1);
                        end else begin
                            wb_dat_o   <= '0;                         // Rejected
                        end
                    end
                end
                WAIT: begin
                    // Hold the host until the loop reaches the requested state
                    if (loop_state_i == loop_req_o) begin
                        host_state <= ACK;
                        if (loop_req_o == RESETTING)
                            loop_req_o <= RUNNING;
                        else if (loop_req_o == WRITE_MANUAL_DONE)
                            loop_req_o <= STOPPED;
                    end
                end
                ACK:     host_state <= IDLE;
                default: host_state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/agc_loop_sequencer.sv
`default_nettype none

module agc_loop_sequencer #(
    parameter int  NBEAMS = 2,
    localparam int BEAM_W = (NBEAMS > 1) ? $clog2(NBEAMS) : 1
) (
    input  wire                       wb_clk_i,
    input  wire                       agc_reset,
    input  wire agc_pkg::loop_state_e loop_req_i,
    output agc_pkg::loop_state_e      loop_state_o,
    output logic                      core_cyc_o,
    output logic                      core_we_o,
    output agc_pkg::adr_t             core_adr_o,
    output agc_pkg::dat_t             core_dat_o,
    input  wire                       core_ack_i,
    input  wire agc_pkg::dat_t        core_dat_i,
    output logic [BEAM_W-1:0]         beam_o,
    output logic                      cnt_wr_o,
    output agc_pkg::count_t           cnt_val_o,
    output logic                      calc_en_o,
    output logic                      thr_restart_o,
    output logic                      commit_o,
    input  wire agc_pkg::thr_t        new_thr_i
);

    import agc_pkg::*;

    localparam int BOOT_W = $clog2(BOOT_DELAY_CYCLES + 1);

    seq_state_e        seq_state;
    bus_phase_e        phase;
    logic [BOOT_W-1:0] boot_cnt;
    logic [BEAM_W:0]   beam_idx;  // One spare bit to count past the last beam
    dat_t              rsp;       // Last read data from the core
    adr_t              beam_off;
    logic              bus_done;
    logic              beam_left;

    assign beam_off  = adr_t'(beam_idx) << 2;
    assign bus_done  = (phase == WAIT_ACK) && core_ack_i;
    assign beam_left = (beam_idx < NBEAMS);

    assign beam_o        = beam_idx[BEAM_W-1:0];
    assign cnt_wr_o      = (seq_state == READ_COUNTS) && (phase == PROCESS);
    assign cnt_val_o     = rsp;
    assign calc_en_o     = (seq_state == CALC) && (loop_state_o != STOPPED) && beam_left;
    assign thr_restart_o = (seq_state == RESET_THR);
    assign commit_o      = (seq_state == UPDATE) && bus_done;

    task automatic bus_req(input logic we, input adr_t adr, input dat_t dat);
        core_cyc_o <= 1'b1;
        core_we_o  <= we;
        core_adr_o <= adr;
        core_dat_o <= dat;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Loop FSM and core bus master
    always_ff @(posedge wb_clk_i) begin
        if (agc_reset) begin
            seq_state    <= BOOT;
            phase        <= SEND;
            boot_cnt     <= BOOT_W'(BOOT_DELAY_CYCLES);
            beam_idx     <= '0;
            loop_state_o <= RUNNING;
            core_cyc_o   <= 1'b0;
            core_we_o    <= 1'b0;
        end else begin
            if (loop_req_i == RUNNING || loop_req_i == STOPPED)
                loop_state_o <= loop_req_i;          // Run and pause take effect at once

            if (bus_done) begin                      // Drop the request after its ack
                core_cyc_o <= 1'b0;
                core_we_o  <= 1'b0;
                rsp        <= core_dat_i;
            end

            case (seq_state)
                BOOT: begin
                    if (boot_cnt != '0) begin
                        boot_cnt <= boot_cnt - 1'b1;
                    end else begin
                        seq_state <= WRITE_THR;      // Send the start thresholds
                        beam_idx  <= '0;
                    end
                end
                POLL: begin
                    // A reset or manual write finished in the last pass
                    if (loop_state_o == RESETTING)
                        loop_state_o <= RUNNING;
                    else if (loop_state_o == WRITE_MANUAL_DONE)
                        loop_state_o <= STOPPED;
                    if (phase == SEND) begin
                        bus_req(1'b1, CORE_ADR_CTRL, CORE_START);
                        phase <= WAIT_ACK;
                    end else if (bus_done) begin
                        seq_state <= WAIT_COUNT;
                        phase     <= SEND;
                    end
                end
                WAIT_COUNT: begin
                    if (phase == SEND) begin
                        if (loop_req_i == RESETTING) begin
                            seq_state <= RESET_THR;
                        end else if (loop_req_i == WRITE_MANUAL_DONE) begin
                            seq_state <= MANUAL;
                        end else begin
                            bus_req(1'b0, CORE_ADR_CTRL, '0);
                            phase <= WAIT_ACK;
                        end
                    end else if (bus_done) begin
                        phase <= PROCESS;
                    end else if (phase == PROCESS) begin
                        phase <= SEND;               // Poll again unless done
                        if (rsp[0]) begin
                            seq_state <= READ_COUNTS;
                            beam_idx  <= '0;
                        end
                    end
                end
                READ_COUNTS: begin
                    if (!beam_left) begin
                        seq_state <= CALC;
                        beam_idx  <= '0;
                    end else if (phase == SEND) begin
                        bus_req(1'b0, CORE_ADR_BEAM_BASE + beam_off, '0);
                        phase <= WAIT_ACK;
                    end else if (bus_done) begin
                        phase <= PROCESS;
                    end else if (phase == PROCESS) begin
                        beam_idx <= beam_idx + 1'b1; // Count is captured by the bank here
                        phase    <= SEND;
                    end
                end
                CALC: begin
                    if (loop_state_o == STOPPED) begin
                        seq_state <= POLL;           // Paused so nothing is sent
                    end else if (beam_left) begin
                        beam_idx <= beam_idx + 1'b1;
                    end else begin
                        seq_state <= WRITE_THR;
                        beam_idx  <= '0;
                    end
                end
                WRITE_THR, APPLY_CE: begin
                    if (!beam_left) begin
                        seq_state <= (seq_state == WRITE_THR) ? APPLY_CE : UPDATE;
                        beam_idx  <= '0;
                    end else if (phase == SEND) begin
                        if (seq_state == WRITE_THR)
                            bus_req(1'b1, CORE_ADR_BEAM_BASE + beam_off, dat_t'(new_thr_i));
                        else
                            bus_req(1'b1, CORE_ADR_CE_BASE + beam_off, dat_t'(1));
                        phase <= WAIT_ACK;
                    end else if (bus_done) begin
                        beam_idx <= beam_idx + 1'b1;
                        phase    <= SEND;
                    end
                end
                UPDATE: begin
                    if (phase == SEND) begin
                        bus_req(1'b1, CORE_ADR_CTRL, CORE_APPLY);
                        phase <= WAIT_ACK;
                    end else if (bus_done) begin
                        seq_state <= POLL;
                        phase     <= SEND;
                        if (loop_state_o == WRITE_RESET)
                            loop_state_o <= RESETTING;
                        else if (loop_state_o == WRITE_MANUAL)
                            loop_state_o <= WRITE_MANUAL_DONE;
                    end
                end
                RESET_THR: begin
                    loop_state_o <= WRITE_RESET;
                    seq_state    <= WRITE_THR;
                    beam_idx     <= '0;
                end
                MANUAL: begin
                    loop_state_o <= WRITE_MANUAL;
                    seq_state    <= WRITE_THR;
                    beam_idx     <= '0;
                end
                default: seq_state <= POLL;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/agc_threshold_bank.sv
`default_nettype none

module agc_threshold_bank #(
    parameter int  NBEAMS       = 2,
    parameter int  TARGET_COUNT = 100,
    parameter int  STEP_DELTA   = 2,
    parameter int  COUNT_MARGIN = 10,
    localparam int BEAM_W       = (NBEAMS > 1) ? $clog2(NBEAMS) : 1
) (
    input  wire                  wb_clk_i,
    input  wire                  agc_reset,
    input  wire [BEAM_W-1:0]     beam_i,
    input  wire                  cnt_wr_i,
    input  wire agc_pkg::count_t cnt_val_i,
    input  wire                  calc_en_i,
    input  wire                  thr_restart_i,
    input  wire                  commit_i,
    input  wire                  man_wr_i,
    input  wire [BEAM_W-1:0]     man_beam_i,
    input  wire agc_pkg::thr_t   man_thr_i,
    input  wire [BEAM_W-1:0]     rd_beam_i,
    output agc_pkg::thr_t        new_thr_o,
    output agc_pkg::count_t      rd_count_o,
    output agc_pkg::thr_t        rd_thr_o
);

    import agc_pkg::*;

    localparam count_t HI_LIMIT = count_t'(TARGET_COUNT + COUNT_MARGIN);
    localparam count_t LO_LIMIT = count_t'(TARGET_COUNT - COUNT_MARGIN);
    localparam thr_t   STEP     = thr_t'(STEP_DELTA);

    count_t count_q  [NBEAMS];
    thr_t   thr_q    [NBEAMS];   // Thresholds the core is running with
    thr_t   recalc_q [NBEAMS];   // Next thresholds, sent on the following write pass

    always_ff @(posedge wb_clk_i) begin
        if (cnt_wr_i)
            count_q[beam_i] <= cnt_val_i;
    end

    always_ff @(posedge wb_clk_i) begin
        if (agc_reset) begin
            for (int b = 0; b < NBEAMS; b++) begin
                thr_q[b]    <= START_THRESH;
                recalc_q[b] <= START_THRESH;
            end
        end else begin
            if (thr_restart_i) begin
                for (int b = 0; b < NBEAMS; b++)
                    recalc_q[b] <= START_THRESH;
            end else if (man_wr_i) begin
                recalc_q[man_beam_i] <= man_thr_i;
            end else if (calc_en_i) begin
                // Fixed step toward the target rate, no clipping
                if (count_q[beam_i] > HI_LIMIT)
                    recalc_q[beam_i] <= thr_q[beam_i] + STEP;
                else if (count_q[beam_i] < LO_LIMIT)
                    recalc_q[beam_i] <= thr_q[beam_i] - STEP;
            end

            if (commit_i)
                thr_q <= recalc_q;                   // Core applied the new set
        end
    end

    assign new_thr_o  = recalc_q[beam_i];
    assign rd_count_o = count_q[rd_beam_i];
    assign rd_thr_o   = thr_q[rd_beam_i];

endmodule

`default_nettype wire

//--- rtl/agc_rate_control.sv
`default_nettype none

module agc_rate_control #(
    parameter int  NBEAMS       = 2,
    parameter int  TARGET_COUNT = 100,
    parameter int  STEP_DELTA   = 2,
    parameter int  COUNT_MARGIN = 10,
    localparam int BEAM_W       = (NBEAMS > 1) ? $clog2(NBEAMS) : 1
) (
    input  wire                wb_clk_i,
    input  wire                agc_reset,
    // Host target port
    input  wire                wb_cyc_i,
    input  wire                wb_stb_i,
    input  wire                wb_we_i,
    input  wire agc_pkg::adr_t wb_adr_i,
    input  wire agc_pkg::dat_t wb_dat_i,
    output logic               wb_ack_o,
    output agc_pkg::dat_t      wb_dat_o,
    // Trigger core master port
    output logic               core_cyc_o,
    output logic               core_we_o,
    output agc_pkg::adr_t      core_adr_o,
    output agc_pkg::dat_t      core_dat_o,
    input  wire                core_ack_i,
    input  wire agc_pkg::dat_t core_dat_i
);

    import agc_pkg::*;

    loop_state_e       loop_req;
    loop_state_e       loop_state;
    logic              man_wr;
    logic [BEAM_W-1:0] man_beam;
    thr_t              man_thr;
    logic [BEAM_W-1:0] rd_beam;
    count_t            rd_count;
    thr_t              rd_thr;
    logic [BEAM_W-1:0] beam;
    logic              cnt_wr;
    count_t            cnt_val;
    logic              calc_en;
    logic              thr_restart;
    logic              commit;
    thr_t              new_thr;

    agc_host_decode #(
        .NBEAMS     (NBEAMS),
        .STEP_DELTA (STEP_DELTA)
    ) u_host_decode (
        .wb_clk_i     (wb_clk_i),
        .agc_reset    (agc_reset),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o),
        .loop_state_i (loop_state),
        .loop_req_o   (loop_req),
        .rd_count_i   (rd_count),
        .rd_thr_i     (rd_thr),
        .man_wr_o     (man_wr),
        .man_beam_o   (man_beam),
        .man_thr_o    (man_thr),
        .rd_beam_o    (rd_beam)
    );

    agc_loop_sequencer #(
        .NBEAMS (NBEAMS)
    ) u_loop_sequencer (
        .wb_clk_i      (wb_clk_i),
        .agc_reset     (agc_reset),
        .loop_req_i    (loop_req),
        .loop_state_o  (loop_state),
        .core_cyc_o    (core_cyc_o),
        .core_we_o     (core_we_o),
        .core_adr_o    (core_adr_o),
        .core_dat_o    (core_dat_o),
        .core_ack_i    (core_ack_i),
        .core_dat_i    (core_dat_i),
        .beam_o        (beam),
        .cnt_wr_o      (cnt_wr),
        .cnt_val_o     (cnt_val),
        .calc_en_o     (calc_en),
        .thr_restart_o (thr_restart),
        .commit_o      (commit),
        .new_thr_i     (new_thr)
    );

    agc_threshold_bank #(
        .NBEAMS       (NBEAMS),
        .TARGET_COUNT (TARGET_COUNT),
        .STEP_DELTA   (STEP_DELTA),
        .COUNT_MARGIN (COUNT_MARGIN)
    ) u_threshold_bank (
        .wb_clk_i      (wb_clk_i),
        .agc_reset     (agc_reset),
        .beam_i        (beam),
        .cnt_wr_i      (cnt_wr),
        .cnt_val_i     (cnt_val),
        .calc_en_i     (calc_en),
        .thr_restart_i (thr_restart),
        .commit_i      (commit),
        .man_wr_i      (man_wr),
        .man_beam_i    (man_beam),
        .man_thr_i     (man_thr),
        .rd_beam_i     (rd_beam),
        .new_thr_o     (new_thr),
        .rd_count_o    (rd_count),
        .rd_thr_o      (rd_thr)
    );

endmodule

`default_nettype wire

//--- sim/trigger_core_model.sv
`default_nettype none

module trigger_core_model #(
    parameter int NBEAMS = 2
) (
    input  wire                wb_clk_i,
    input  wire                agc_reset,
    input  wire                core_cyc_i,
    input  wire                core_we_i,
    input  wire agc_pkg::adr_t core_adr_i,
    input  wire agc_pkg::dat_t core_dat_i,
    output logic               core_ack_o,
    output agc_pkg::dat_t      core_dat_o
);

    import agc_pkg::*;

    integer seed;
    int     lat;                   // Cycles left before ack, -1 when idle
    int     polls;                 // Control reads since the last start
    int     idx;
    count_t count_cfg [NBEAMS];    // Counts returned on beam reads
    dat_t   thr_rec   [NBEAMS];    // Last threshold written per beam
    int     apply_count;
    int     poll_total;

    initial begin
        seed = 32'hb9be_11b4;
        for (int b = 0; b < NBEAMS; b++)
            count_cfg[b] <= 32'd100;
    end

    always @(posedge wb_clk_i) begin
        core_ack_o <= 1'b0;
        if (agc_reset) begin
            lat         = -1;
            polls       = 0;
            apply_count = 0;
            poll_total  = 0;
            core_dat_o <= '0;
            for (int b = 0; b < NBEAMS; b++)
                thr_rec[b] = '0;
        end else if (core_cyc_i && !core_ack_o) begin
            if (lat < 0) begin
                lat = {$random(seed)} % 3;         // Ack after 1 to 3 cycles
            end else if (lat > 0) begin
                lat = lat - 1;
            end else begin
                lat = -1;
                core_ack_o <= 1'b1;
                idx = int'((core_adr_i - CORE_ADR_BEAM_BASE) >> 2);
                if (core_adr_i == CORE_ADR_CTRL) begin
                    if (core_we_i && core_dat_i == CORE_START)
                        polls = 0;
                    else if (core_we_i && core_dat_i == CORE_APPLY)
                        apply_count = apply_count + 1;
                    else if (!core_we_i) begin
                        polls      = polls + 1;
                        poll_total = poll_total + 1;
                        core_dat_o <= (polls >= 2) ? dat_t'(1) : '0;  // Done on second poll
                    end
                end else if (core_adr_i >= CORE_ADR_BEAM_BASE && idx < NBEAMS) begin
                    if (core_we_i)
                        thr_rec[idx] = core_dat_i;
                    else
                        core_dat_o <= count_cfg[idx];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_agc_rate_control.sv
`default_nettype none

module tb_agc_rate_control;

    import agc_pkg::*;

    localparam int NBEAMS     = 2;
    localparam int STEP_DELTA = 2;
    localparam int MAX_CYCLES = 20000;  // About 25 loop passes of under 60 cycles, wide margin

    logic wb_clk_i;
    logic agc_reset;
    logic wb_cyc_i;
    logic wb_stb_i;
    logic wb_we_i;
    adr_t wb_adr_i;
    dat_t wb_dat_i;
    logic wb_ack_o;
    dat_t wb_dat_o;
    logic core_cyc_o;
    logic core_we_o;
    adr_t core_adr_o;
    dat_t core_dat_o;
    logic core_ack_i;
    dat_t core_dat_i;

    int cycles = 0;
    int mark;                           // Apply count when the 200/20 step was checked
    int hold0;

    agc_rate_control #(
        .NBEAMS       (NBEAMS),
        .TARGET_COUNT (100),
        .STEP_DELTA   (STEP_DELTA),
        .COUNT_MARGIN (10)
    ) u_agc_rate_control (
        .wb_clk_i   (wb_clk_i),
        .agc_reset  (agc_reset),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_o   (wb_ack_o),
        .wb_dat_o   (wb_dat_o),
        .core_cyc_o (core_cyc_o),
        .core_we_o  (core_we_o),
        .core_adr_o (core_adr_o),
        .core_dat_o (core_dat_o),
        .core_ack_i (core_ack_i),
        .core_dat_i (core_dat_i)
    );

    trigger_core_model #(
        .NBEAMS (NBEAMS)
    ) u_trigger_core_model (
        .wb_clk_i   (wb_clk_i),
        .agc_reset  (agc_reset),
        .core_cyc_i (core_cyc_o),
        .core_we_i  (core_we_o),
        .core_adr_i (core_adr_o),
        .core_dat_i (core_dat_o),
        .core_ack_o (core_ack_i),
        .core_dat_o (core_dat_i)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #2 wb_clk_i = ~wb_clk_i;
    end

    always @(posedge wb_clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    task automatic check_eq(input longint actual, input longint expected, input string msg);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t: %s (got %0d, expected %0d)",
                     $time, msg, actual, expected);
            $display("Test failures found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    function automatic adr_t thr_adr(input int b);
        return adr_t'(22'h000800 + 4 * b);  // Also the manual write window
    endfunction

    function automatic adr_t cnt_adr(input int b);
        return adr_t'(22'h000400 + 4 * b);
    endfunction

    task automatic host_read(input adr_t adr, output dat_t data);
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b0;
        wb_adr_i <= adr;
        do @(negedge wb_clk_i); while (!wb_ack_o);
        data = wb_dat_o;
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    task automatic host_write(input adr_t adr, input dat_t dat, output dat_t resp);
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        do @(negedge wb_clk_i); while (!wb_ack_o);  // Latency follows the loop
        resp = wb_dat_o;
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic wait_applies(input int n);
        int target;
        @(negedge wb_clk_i);
        target = u_trigger_core_model.apply_count + n;
        while (u_trigger_core_model.apply_count < target)
            @(negedge wb_clk_i);
    endtask

    task automatic set_counts(input count_t c0, input count_t c1);
        @(posedge wb_clk_i);
        u_trigger_core_model.count_cfg[0] <= c0;
        u_trigger_core_model.count_cfg[1] <= c1;
    endtask

    task automatic check_thr(input int b, input int expected, input string msg);
        dat_t d;
        host_read(thr_adr(b), d);
        check_eq(d, expected, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    task automatic test_boot();
        @(negedge wb_clk_i);
        check_eq(wb_ack_o, 0, "host ack low after reset");
        check_eq(core_cyc_o, 0, "core cycle low during boot delay");
        wait_applies(1);
        for (int b = 0; b < NBEAMS; b++) begin
            check_eq(u_trigger_core_model.thr_rec[b], START_THRESH, "boot threshold in core");
            check_thr(b, START_THRESH, "boot threshold read");
        end
    endtask

    task automatic test_step_rule();
        dat_t d;
        wait_applies(1);
        set_counts(200, 20);
        wait_applies(1);                    // First pass that saw the new counts
        mark = u_trigger_core_model.apply_count;
        check_thr(0, START_THRESH + STEP_DELTA, "beam 0 stepped up");
        check_thr(1, START_THRESH - STEP_DELTA, "beam 1 stepped down");
        host_read(cnt_adr(0), d);
        check_eq(d, 200, "beam 0 count");
        host_read(cnt_adr(1), d);
        check_eq(d, 20, "beam 1 count");
    endtask

    task automatic test_margin();
        dat_t d;
        int   steps;
        wait_applies(1);
        set_counts(100, 105);
        // Every pass since the mark still used 200 and 20
        steps = 1 + u_trigger_core_model.apply_count - mark;
        check_thr(0, START_THRESH + STEP_DELTA * steps, "beam 0 before margin test");
        check_thr(1, START_THRESH - STEP_DELTA * steps, "beam 1 before margin test");
        wait_applies(3);
        check_thr(0, START_THRESH + STEP_DELTA * steps, "beam 0 held inside margin");
        check_thr(1, START_THRESH - STEP_DELTA * steps, "beam 1 held inside margin");
        host_read(cnt_adr(1), d);
        check_eq(d, 105, "beam 1 count inside margin");
        host_read('0, d);
        check_eq(d, STEP_DELTA, "step size read");
        hold0 = START_THRESH + STEP_DELTA * steps;
    endtask

    task automatic test_pause_manual();
        dat_t resp;
        int   applies;
        int   polls;
        host_write(ADR_CMD, dat_t'(CMD_PAUSE), resp);
        host_write(thr_adr(1), 1234, resp);
        check_eq(resp, 1, "manual write accepted");
        check_thr(1, 1234, "manual threshold read");
        check_eq(u_trigger_core_model.thr_rec[1], 1234, "manual threshold in core");
        applies = u_trigger_core_model.apply_count;
        polls   = u_trigger_core_model.poll_total;
        while (u_trigger_core_model.poll_total < polls + 6)
            @(negedge wb_clk_i);
        check_eq(u_trigger_core_model.apply_count, applies, "no apply while paused");
        check_thr(0, hold0, "beam 0 frozen while paused");
        check_thr(1, 1234, "beam 1 frozen while paused");
    endtask

    task automatic test_run_and_reset();
        dat_t resp;
        host_write(ADR_CMD, dat_t'(CMD_RUN), resp);
        host_write(thr_adr(0), 777, resp);
        check_eq(resp, 0, "manual write rejected while running");
        check_thr(0, hold0, "beam 0 unchanged by rejected write");
        check_thr(1, 1234, "beam 1 unchanged by rejected write");
        host_write(ADR_CMD, dat_t'(CMD_RESET), resp);
        for (int b = 0; b < NBEAMS; b++)
            check_thr(b, START_THRESH, "threshold after reset command");
        wait_applies(1);
        for (int b = 0; b < NBEAMS; b++)
            check_eq(u_trigger_core_model.thr_rec[b], START_THRESH, "core after reset command");
    endtask

    initial begin
        agc_reset = 1'b1;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        repeat (8) @(posedge wb_clk_i);
        agc_reset <= 1'b0;

        test_boot();
        test_step_rule();
        test_margin();
        test_pause_manual();
        test_run_and_reset();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- agc_rate_control.f
rtl/agc_pkg.sv
rtl/agc_host_decode.sv
rtl/agc_loop_sequencer.sv
rtl/agc_threshold_bank.sv
rtl/agc_rate_control.sv
sim/trigger_core_model.sv
sim/tb_agc_rate_control.sv
